// File: build.f
design/cxt_pkg.sv
design/ceu_cmd_decode.sv
design/eqc_wr_thread.sv
design/icm_addr_map.sv
design/eqc_cache.sv
design/eqc_rsp_gen.sv
design/cxt_mgr_top.sv
tests/tb_cxt_mgr.sv

// File: run_sim.sh
#!/bin/sh
# build the EQC context manager testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_cxt_mgr -Mdir obj_dir -o sim_cxt_mgr
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_cxt_mgr
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: tests/tb_cxt_mgr.sv
/* directed tests for the EQC context manager; inputs change on the falling edge,
   and the first mismatch stops the run */
`default_nettype none

module tb_cxt_mgr;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic                           clk;
    logic                           rst;
    logic                           cmd_valid;
    cxt_pkg::ceu_head_t             cmd_head;
    logic [cxt_pkg::CXT_DATA_W-1:0] cmd_data;
    logic                           cmd_last;
    logic                           cmd_ready;
    logic                           rsp_valid;
    cxt_pkg::eqc_rsp_t              rsp;
    logic                           rsp_ready;

    integer                         seed = 2;
    // fields last written to index 5, reused by the back-pressure test
    cxt_pkg::eqc_fields_t           fields_idx5;

    cxt_mgr_top cxt_mgr_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // whole run gets a fixed cycle budget
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST + 10) @(posedge clk);
        fail_run("watchdog expired before all tests finished");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_rsp(input cxt_pkg::eqc_rsp_t got, input cxt_pkg::eqc_rsp_t exp);
        if (got !== exp)
            fail_run($sformatf("error rsp got 0x%h expected 0x%h", got, exp));
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    function automatic cxt_pkg::ceu_head_t make_head(input logic [3:0] op,
                                                     input logic [31:0] idx);
        cxt_pkg::ceu_head_t h;
        h        = '0;
        h.opcode = op;
        h.index  = idx;
        return h;
    endfunction

    function automatic cxt_pkg::eqc_rsp_t make_rsp(input logic [1:0] st, input logic [31:0] idx,
                                                   input cxt_pkg::eqc_fields_t f);
        cxt_pkg::eqc_rsp_t r;
        r.status = st;
        r.index  = idx;
        r.fields = f;
        return r;
    endfunction

    // context fields sit in the second write beat at fixed offsets
    function automatic cxt_pkg::eqc_fields_t fields_of(
        input logic [cxt_pkg::CXT_DATA_W-1:0] beat
    );
        cxt_pkg::eqc_fields_t f;
        f.log_size    = beat[127:120];
        f.msix_vector = beat[159:128];
        f.eq_pd       = beat[191:160];
        f.eq_lkey     = beat[223:192];
        return f;
    endfunction

    task automatic rand_beat(output logic [cxt_pkg::CXT_DATA_W-1:0] beat);
        int i;
        for (i = 0; i < cxt_pkg::CXT_DATA_W / 32; i++) beat[i*32 +: 32] = $random(seed);
    endtask

    // cmd_ready comes from registered state, so it is settled at the falling edge
    task automatic wait_accept();
        while (!cmd_ready) @(negedge clk);
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd_last  = 1'b0;
    endtask

    task automatic drive_beat(input cxt_pkg::ceu_head_t head,
                              input logic [cxt_pkg::CXT_DATA_W-1:0] data, input logic last);
        cmd_head  = head;
        cmd_data  = data;
        cmd_last  = last;
        cmd_valid = 1'b1;
        wait_accept();
    endtask

    task automatic send_map(input logic [31:0] idx);
        logic [cxt_pkg::CXT_DATA_W-1:0] data;
        logic [63:0]                    r;
        r    = {$random(seed), $random(seed)};
        data = '0;
        data[cxt_pkg::MAP_PHY_LSB +: cxt_pkg::PHY_ADDR_W] = r[cxt_pkg::PHY_ADDR_W-1:0];
        drive_beat(make_head(cxt_pkg::OP_MAP_EQC, idx), data, 1'b1);
    endtask

    // gap is the number of idle cycles between the two data beats
    task automatic send_write(input logic [31:0] idx, input logic [cxt_pkg::CXT_DATA_W-1:0] d0,
                              input logic [cxt_pkg::CXT_DATA_W-1:0] d1, input int gap);
        drive_beat(make_head(cxt_pkg::OP_WR_EQC_ALL, idx), d0, 1'b0);
        repeat (gap) @(negedge clk);
        drive_beat(make_head(cxt_pkg::OP_WR_EQC_ALL, idx), d1, 1'b1);
    endtask

    task automatic send_read(input logic [31:0] idx);
        drive_beat(make_head(cxt_pkg::OP_RD_EQC, idx), '0, 1'b1);
    endtask

    task automatic recv_rsp(input cxt_pkg::eqc_rsp_t exp);
        while (!rsp_valid) @(negedge clk);
        check_rsp(rsp, exp);
        @(negedge clk);
    endtask

    task automatic test_map_write_read();
        logic [cxt_pkg::CXT_DATA_W-1:0] d0;
        logic [cxt_pkg::CXT_DATA_W-1:0] d1;
        rand_beat(d0);
        rand_beat(d1);
        fields_idx5 = fields_of(d1);
        send_map(32'd5);
        send_write(32'd5, d0, d1, 0);
        send_read(32'd5);
        recv_rsp(make_rsp(cxt_pkg::ST_HIT, 32'd5, fields_idx5));
    endtask

    task automatic test_read_unwritten();
        send_read(32'd9);
        recv_rsp(make_rsp(cxt_pkg::ST_MISS, 32'd9, '0));
    endtask

    task automatic test_write_unmapped();
        logic [cxt_pkg::CXT_DATA_W-1:0] d0;
        logic [cxt_pkg::CXT_DATA_W-1:0] d1;
        rand_beat(d0);
        rand_beat(d1);
        // both beats must still be taken
        send_write(32'd11, d0, d1, 1);
        send_read(32'd11);
        recv_rsp(make_rsp(cxt_pkg::ST_MISS, 32'd11, '0));
    endtask

    task automatic test_unknown_opcode();
        logic [cxt_pkg::CXT_DATA_W-1:0] d0;
        logic [cxt_pkg::CXT_DATA_W-1:0] d1;
        rand_beat(d0);
        rand_beat(d1);
        drive_beat(make_head(4'hC, 32'h5A00_0007), d0, 1'b0);
        drive_beat(make_head(4'hC, 32'h5A00_0007), d1, 1'b1);
        recv_rsp(make_rsp(cxt_pkg::ST_BAD_OP, 32'h5A00_0007, '0));
    endtask

    task automatic test_back_pressure();
        cxt_pkg::eqc_rsp_t exp_a;
        cxt_pkg::eqc_rsp_t exp_b;
        exp_a     = make_rsp(cxt_pkg::ST_HIT, 32'd5, fields_idx5);
        exp_b     = make_rsp(cxt_pkg::ST_MISS, 32'd9, '0);
        rsp_ready = 1'b0;
        send_read(32'd5);
        while (!rsp_valid) @(negedge clk);
        // second read sits on the bus while the first response is held
        cmd_head  = make_head(cxt_pkg::OP_RD_EQC, 32'd9);
        cmd_data  = '0;
        cmd_last  = 1'b1;
        cmd_valid = 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_ready("cmd_ready", cmd_ready, 1'b0);
            check_ready("rsp_valid", rsp_valid, 1'b1);
            check_rsp(rsp, exp_a);
        end
        rsp_ready = 1'b1;
        recv_rsp(exp_a);
        wait_accept();
        recv_rsp(exp_b);
    endtask

    task automatic test_stalled_write();
        logic [cxt_pkg::CXT_DATA_W-1:0] d0;
        logic [cxt_pkg::CXT_DATA_W-1:0] d1;
        rand_beat(d0);
        rand_beat(d1);
        send_map(32'd12);
        send_write(32'd12, d0, d1, 3);
        send_read(32'd12);
        recv_rsp(make_rsp(cxt_pkg::ST_HIT, 32'd12, fields_of(d1)));
        // overwrite with fresh data and a longer stall
        rand_beat(d0);
        rand_beat(d1);
        send_write(32'd12, d0, d1, 5);
        send_read(32'd12);
        recv_rsp(make_rsp(cxt_pkg::ST_HIT, 32'd12, fields_of(d1)));
    endtask

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_head  = '0;
        cmd_data  = '0;
        cmd_last  = 1'b0;
        rsp_ready = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_ready("cmd_ready", cmd_ready, 1'b0);
        check_ready("rsp_valid", rsp_valid, 1'b0);
        test_map_write_read();
        test_read_unwritten();
        test_write_unmapped();
        test_unknown_opcode();
        test_back_pressure();
        test_stalled_write();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/cxt_mgr_top.sv
/* EQC context manager slice; commands in on cmd_*, responses out on rsp_* */
`default_nettype none

module cxt_mgr_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                cmd_valid,
    input  wire cxt_pkg::ceu_head_t            cmd_head,
    input  wire [cxt_pkg::CXT_DATA_W-1:0]      cmd_data,
    input  wire                                cmd_last,
    output logic                               cmd_ready,
    output logic                               rsp_valid,
    output cxt_pkg::eqc_rsp_t                  rsp,
    input  wire                                rsp_ready
);

    // decode to table / writer / responder
    logic                           map_set_valid;
    cxt_pkg::map_set_t              map_set;
    logic                           wr_start;
    cxt_pkg::ceu_head_t             wr_head;
    logic                           wr_beat_valid;
    logic [cxt_pkg::CXT_DATA_W-1:0] wr_beat_data;
    logic                           wr_beat_ready;
    logic                           wr_busy;
    logic                           rd_req;
    logic [cxt_pkg::CMD_IDX_W-1:0]  rd_index;
    logic                           bad_op;
    logic                           rsp_busy;
    // writer to table and cache
    logic                           map_lookup_valid;
    logic [cxt_pkg::EQC_IDX_W-1:0]  map_lookup_index;
    logic                           map_lookup_ready;
    logic                           map_rsp_valid;
    cxt_pkg::map_rsp_t              map_rsp;
    logic                           map_rsp_ready;
    logic                           cache_set_valid;
    cxt_pkg::cache_set_t            cache_set;
    // responder read port
    logic [cxt_pkg::ICM_ADDR_W-1:0] rd_icm_addr;
    cxt_pkg::cache_rd_t             rd_data;

    ceu_cmd_decode ceu_cmd_decode_i (.*);

    eqc_wr_thread eqc_wr_thread_i (.*);

    icm_addr_map icm_addr_map_i (.*);

    eqc_cache eqc_cache_i (.*);

    eqc_rsp_gen eqc_rsp_gen_i (.*);

endmodule

`default_nettype wire

// File: design/eqc_rsp_gen.sv
/* one response buffered; callers must hold off while rsp_busy is high */
`default_nettype none

module eqc_rsp_gen (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                rd_req,
    input  wire [cxt_pkg::CMD_IDX_W-1:0]       rd_index,
    input  wire                                bad_op,
    input  wire                                rsp_ready,
    input  wire cxt_pkg::cache_rd_t            rd_data,
    output logic [cxt_pkg::ICM_ADDR_W-1:0]     rd_icm_addr,
    output logic                               rsp_busy,
    output logic                               rsp_valid,
    output cxt_pkg::eqc_rsp_t                  rsp
);

    // cache lookup uses the same icm layout as the table
    assign rd_icm_addr = cxt_pkg::eqc_icm_addr(rd_index[cxt_pkg::EQC_IDX_W-1:0]);
    // busy from the strobe on, so a second command cannot slip in
    assign rsp_busy    = rsp_valid || rd_req || bad_op;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (rd_req || bad_op) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // payload only loads on a strobe, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rsp.status <= rd_data.present ? cxt_pkg::ST_HIT : cxt_pkg::ST_MISS;
            rsp.index  <= rd_index;
            // miss reports zero fields
            rsp.fields <= rd_data.present ? rd_data.fields : '0;
        end else if (bad_op) begin
            rsp.status <= cxt_pkg::ST_BAD_OP;
            rsp.index  <= rd_index;
            rsp.fields <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

// File: design/eqc_cache.sv
/* sets always complete in one cycle; the read port is combinational on rd_icm_addr */
`default_nettype none

module eqc_cache (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                cache_set_valid,
    input  wire cxt_pkg::cache_set_t           cache_set,
    input  wire [cxt_pkg::ICM_ADDR_W-1:0]      rd_icm_addr,
    output cxt_pkg::cache_rd_t                 rd_data
);

    logic [cxt_pkg::EQC_ENTRY_NUM-1:0] present;
    logic [cxt_pkg::PHY_ADDR_W-1:0]    phy_mem [cxt_pkg::EQC_ENTRY_NUM];
    cxt_pkg::eqc_fields_t              fld_mem [cxt_pkg::EQC_ENTRY_NUM];
    logic [cxt_pkg::EQC_IDX_W-1:0]     set_slot;
    logic [cxt_pkg::EQC_IDX_W-1:0]     rd_slot;

    // slot is the offset from the table base in entry units
    function automatic logic [cxt_pkg::EQC_IDX_W-1:0] slot_of(
        input logic [cxt_pkg::ICM_ADDR_W-1:0] addr
    );
        logic [cxt_pkg::ICM_ADDR_W-1:0] off;
        off = (addr - cxt_pkg::EQC_ICM_BASE) / cxt_pkg::EQC_ENTRY_BYTES;
        return off[cxt_pkg::EQC_IDX_W-1:0];
    endfunction

    assign set_slot = slot_of(cache_set.icm_addr);
    assign rd_slot  = slot_of(rd_icm_addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            present <= '0;
        end else if (cache_set_valid) begin
            present[set_slot] <= 1'b1;
        end
    end

    // context storage, overwrite replaces the whole entry
    always_ff @(posedge clk) begin
        if (cache_set_valid) begin
            phy_mem[set_slot] <= cache_set.phy_addr;
            fld_mem[set_slot] <= cache_set.fields;
        end
    end

    assign rd_data.present  = present[rd_slot];
    assign rd_data.phy_addr = phy_mem[rd_slot];
    assign rd_data.fields   = fld_mem[rd_slot];

    // translated addresses land on entry boundaries
    assert property (@(posedge clk) disable iff (rst) cache_set_valid |->
        (cache_set.icm_addr - cxt_pkg::EQC_ICM_BASE) % cxt_pkg::EQC_ENTRY_BYTES == '0);

endmodule

`default_nettype wire

// File: design/icm_addr_map.sv
/* one lookup outstanding; a set becomes visible to a lookup in the following cycle */
`default_nettype none

module icm_addr_map (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                map_set_valid,
    input  wire cxt_pkg::map_set_t             map_set,
    input  wire                                map_lookup_valid,
    input  wire [cxt_pkg::EQC_IDX_W-1:0]       map_lookup_index,
    input  wire                                map_rsp_ready,
    output logic                               map_lookup_ready,
    output logic                               map_rsp_valid,
    output cxt_pkg::map_rsp_t                  map_rsp
);

    logic [cxt_pkg::PHY_ADDR_W-1:0]   phy_mem [cxt_pkg::EQC_ENTRY_NUM];
    logic [cxt_pkg::EQC_ENTRY_NUM-1:0] ent_valid;
    logic                             lookup_acc;

    // free unless an answer is still waiting
    assign map_lookup_ready = !map_rsp_valid || map_rsp_ready;
    assign lookup_acc       = map_lookup_valid && map_lookup_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid     <= '0;
            map_rsp_valid <= 1'b0;
        end else begin
            if (map_set_valid) ent_valid[map_set.index] <= 1'b1;
            if (lookup_acc) begin
                map_rsp_valid <= 1'b1;
            end else if (map_rsp_ready) begin
                map_rsp_valid <= 1'b0;
            end
        end
    end

    // translation storage
    always_ff @(posedge clk) begin
        if (map_set_valid) phy_mem[map_set.index] <= map_set.phy_addr;
    end

    // answer held until taken
    always_ff @(posedge clk) begin
        if (lookup_acc) begin
            map_rsp.hit      <= ent_valid[map_lookup_index];
            map_rsp.icm_addr <= cxt_pkg::eqc_icm_addr(map_lookup_index);
            map_rsp.phy_addr <= phy_mem[map_lookup_index];
        end
    end

endmodule

`default_nettype wire

// File: design/eqc_wr_thread.sv
/* fields come from the second data beat only; a lookup miss drains both beats and
   leaves the cache untouched */
`default_nettype none

module eqc_wr_thread (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                wr_start,
    input  wire cxt_pkg::ceu_head_t            wr_head,
    input  wire                                wr_beat_valid,
    input  wire [cxt_pkg::CXT_DATA_W-1:0]      wr_beat_data,
    input  wire                                map_lookup_ready,
    input  wire                                map_rsp_valid,
    input  wire cxt_pkg::map_rsp_t             map_rsp,
    output logic                               wr_beat_ready,
    output logic                               wr_busy,
    output logic                               map_lookup_valid,
    output logic [cxt_pkg::EQC_IDX_W-1:0]      map_lookup_index,
    output logic                               map_rsp_ready,
    output logic                               cache_set_valid,
    output cxt_pkg::cache_set_t                cache_set
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR_REQ,
        S_ADDR_RSP,
        S_COLLECT,
        S_CACHE_SET
    } state_t;

    state_t                                    state;
    logic [$clog2(cxt_pkg::EQC_PIECE_NUM+1)-1:0] piece_cnt;
    logic                                      beat_acc;
    logic                                      last_beat;
    logic [cxt_pkg::EQC_IDX_W-1:0]             idx_q;
    logic                                      hit_q;
    logic [cxt_pkg::ICM_ADDR_W-1:0]            icm_q;
    logic [cxt_pkg::PHY_ADDR_W-1:0]            phy_q;
    cxt_pkg::eqc_fields_t                      fields_q;

    assign beat_acc  = wr_beat_valid && wr_beat_ready;
    assign last_beat = beat_acc && piece_cnt == cxt_pkg::EQC_PIECE_NUM - 1;

    // handshakes follow the state directly
    assign wr_busy          = state != S_IDLE;
    assign map_lookup_valid = state == S_ADDR_REQ;
    assign map_lookup_index = idx_q;
    assign map_rsp_ready    = state == S_ADDR_RSP;
    assign wr_beat_ready    = state == S_COLLECT;
    assign cache_set_valid  = state == S_CACHE_SET;

    assign cache_set.icm_addr = icm_q;
    assign cache_set.phy_addr = phy_q;
    assign cache_set.fields   = fields_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            piece_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (wr_start) begin
                        state     <= S_ADDR_REQ;
                        piece_cnt <= '0;
                    end
                end
                S_ADDR_REQ: if (map_lookup_ready) state <= S_ADDR_RSP;
                S_ADDR_RSP: if (map_rsp_valid) state <= S_COLLECT;
                S_COLLECT: begin
                    if (beat_acc) piece_cnt <= piece_cnt + 1'b1;
                    // miss still consumes every beat
                    if (last_beat) state <= hit_q ? S_CACHE_SET : S_IDLE;
                end
                S_CACHE_SET: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // index, translation result, context fields
    always_ff @(posedge clk) begin
        if (state == S_IDLE && wr_start) idx_q <= wr_head.index[cxt_pkg::EQC_IDX_W-1:0];
        if (state == S_ADDR_RSP && map_rsp_valid) begin
            hit_q <= map_rsp.hit;
            icm_q <= map_rsp.icm_addr;
            phy_q <= map_rsp.phy_addr;
        end
        if (state == S_COLLECT && last_beat) begin
            fields_q.log_size    <= wr_beat_data[cxt_pkg::FLD_LOG_SIZE_LSB +: 8];
            fields_q.msix_vector <= wr_beat_data[cxt_pkg::FLD_MSIX_LSB +: 32];
            fields_q.eq_pd       <= wr_beat_data[cxt_pkg::FLD_PD_LSB +: 32];
            fields_q.eq_lkey     <= wr_beat_data[cxt_pkg::FLD_LKEY_LSB +: 32];
        end
    end

    // cache set follows the final beat directly
    assert property (@(posedge clk) disable iff (rst)
        cache_set_valid |-> piece_cnt == cxt_pkg::EQC_PIECE_NUM && $past(beat_acc));

endmodule

`default_nettype wire

// File: design/ceu_cmd_decode.sv
/* a beat stays on the bus until its owner takes it; one command is in flight at a time */
`default_nettype none

module ceu_cmd_decode (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                cmd_valid,
    input  wire cxt_pkg::ceu_head_t            cmd_head,
    input  wire [cxt_pkg::CXT_DATA_W-1:0]      cmd_data,
    input  wire                                cmd_last,
    input  wire                                wr_beat_ready,
    input  wire                                wr_busy,
    input  wire                                rsp_busy,
    output logic                               cmd_ready,
    output logic                               map_set_valid,
    output cxt_pkg::map_set_t                  map_set,
    output logic                               wr_start,
    output cxt_pkg::ceu_head_t                 wr_head,
    output logic                               wr_beat_valid,
    output logic [cxt_pkg::CXT_DATA_W-1:0]     wr_beat_data,
    output logic                               rd_req,
    output logic [cxt_pkg::CMD_IDX_W-1:0]      rd_index,
    output logic                               bad_op
);

    typedef enum logic [1:0] {S_IDLE, S_ROUTE, S_DRAIN, S_WAIT_WR} state_t;

    state_t             state;
    state_t             state_nx;
    cxt_pkg::ceu_head_t head_q;
    logic               is_map;
    logic               is_rd;
    logic               is_wr;

    // opcode of the latched header
    assign is_map = head_q.opcode == cxt_pkg::OP_MAP_EQC;
    assign is_rd  = head_q.opcode == cxt_pkg::OP_RD_EQC;
    assign is_wr  = head_q.opcode == cxt_pkg::OP_WR_EQC_ALL;

    // writer sees the header and beats directly
    assign wr_head      = head_q;
    assign wr_beat_data = cmd_data;

    always_comb begin
        state_nx      = state;
        cmd_ready     = 1'b0;
        wr_start      = 1'b0;
        wr_beat_valid = 1'b0;
        case (state)
            S_IDLE: begin
                // header sampled here, beat not taken yet
                if (cmd_valid) state_nx = S_ROUTE;
            end
            S_ROUTE: begin
                if (is_map) begin
                    cmd_ready = 1'b1;
                    if (cmd_valid) state_nx = S_IDLE;
                end else if (is_rd) begin
                    // stall reads while a response is pending
                    cmd_ready = !rsp_busy;
                    if (cmd_valid && !rsp_busy) state_nx = S_IDLE;
                end else if (is_wr) begin
                    wr_start = 1'b1;
                    state_nx = S_WAIT_WR;
                end else begin
                    state_nx = S_DRAIN;
                end
            end
            S_DRAIN: begin
                cmd_ready = !rsp_busy;
                if (cmd_valid && !rsp_busy && cmd_last) state_nx = S_IDLE;
            end
            S_WAIT_WR: begin
                // writer owns the bus until it goes idle
                wr_beat_valid = cmd_valid;
                cmd_ready     = wr_beat_ready;
                if (!wr_busy) state_nx = S_IDLE;
            end
            default: state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= S_IDLE;
            map_set_valid <= 1'b0;
            rd_req        <= 1'b0;
            bad_op        <= 1'b0;
        end else begin
            state         <= state_nx;
            map_set_valid <= state == S_ROUTE && is_map && cmd_valid;
            rd_req        <= state == S_ROUTE && is_rd && cmd_valid && !rsp_busy;
            bad_op        <= state == S_DRAIN && cmd_valid && !rsp_busy && cmd_last;
        end
    end

    // header, map payload and response index
    always_ff @(posedge clk) begin
        if (state == S_IDLE && cmd_valid) head_q <= cmd_head;
        if (state == S_ROUTE && is_map && cmd_valid) begin
            map_set.index    <= head_q.index[cxt_pkg::EQC_IDX_W-1:0];
            map_set.phy_addr <= cmd_data[cxt_pkg::MAP_PHY_LSB +: cxt_pkg::PHY_ADDR_W];
        end
        if (state != S_IDLE) rd_index <= head_q.index;
    end

    // handover only to an idle writer, which then reports busy
    assert property (@(posedge clk) disable iff (rst) wr_start |-> !wr_busy ##1 wr_busy);

endmodule

`default_nettype wire

// File: design/cxt_pkg.sv
/* shared EQC definitions; only the low EQC_IDX_W bits of a command index select a slot,
   and ICM slots are packed from EQC_ICM_BASE in EQC_ENTRY_BYTES steps */
`default_nettype none

package cxt_pkg;

    // beat and address widths
    localparam int CXT_DATA_W    = 256;
    localparam int CMD_IDX_W     = 32;
    localparam int EQC_IDX_W     = 4;
    localparam int EQC_ENTRY_NUM = 16;
    localparam int EQC_PIECE_NUM = 2;
    localparam int ICM_ADDR_W    = 32;
    localparam int PHY_ADDR_W    = 48;

    // icm layout of the eqc table
    localparam logic [ICM_ADDR_W-1:0] EQC_ICM_BASE    = 32'h0004_0000;
    localparam logic [ICM_ADDR_W-1:0] EQC_ENTRY_BYTES = 32'd64;

    // ceu opcodes
    localparam logic [3:0] OP_MAP_EQC    = 4'h1;
    localparam logic [3:0] OP_WR_EQC_ALL = 4'h2;
    localparam logic [3:0] OP_RD_EQC     = 4'h3;

    // field positions in the second write beat
    localparam int FLD_LOG_SIZE_LSB = 120;
    localparam int FLD_MSIX_LSB     = 128;
    localparam int FLD_PD_LSB       = 160;
    localparam int FLD_LKEY_LSB     = 192;
    // phy address inside a map beat
    localparam int MAP_PHY_LSB      = 0;

    // response status
    localparam logic [1:0] ST_HIT    = 2'd1;
    localparam logic [1:0] ST_MISS   = 2'd2;
    localparam logic [1:0] ST_BAD_OP = 2'd3;

    typedef struct packed {
        logic [3:0]           opcode;
        logic [CMD_IDX_W-1:0] index;
        logic [91:0]          rsvd;
    } ceu_head_t;

    typedef struct packed {
        logic [7:0]  log_size;
        logic [31:0] msix_vector;
        logic [31:0] eq_pd;
        logic [31:0] eq_lkey;
    } eqc_fields_t;

    typedef struct packed {
        logic [EQC_IDX_W-1:0]  index;
        logic [PHY_ADDR_W-1:0] phy_addr;
    } map_set_t;

    typedef struct packed {
        logic                  hit;
        logic [ICM_ADDR_W-1:0] icm_addr;
        logic [PHY_ADDR_W-1:0] phy_addr;
    } map_rsp_t;

    typedef struct packed {
        logic [ICM_ADDR_W-1:0] icm_addr;
        logic [PHY_ADDR_W-1:0] phy_addr;
        eqc_fields_t           fields;
    } cache_set_t;

    typedef struct packed {
        logic                  present;
        logic [PHY_ADDR_W-1:0] phy_addr;
        eqc_fields_t           fields;
    } cache_rd_t;

    typedef struct packed {
        logic [1:0]           status;
        logic [CMD_IDX_W-1:0] index;
        eqc_fields_t          fields;
    } eqc_rsp_t;

    // icm address of an eqc slot
    function automatic logic [ICM_ADDR_W-1:0] eqc_icm_addr(input logic [EQC_IDX_W-1:0] idx);
        return EQC_ICM_BASE + {{(ICM_ADDR_W - EQC_IDX_W){1'b0}}, idx} * EQC_ENTRY_BYTES;
    endfunction

endpackage

`default_nettype wire
